// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_prio_sched
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
common/sched_pkg.sv
max_finder/max_finder_pow2.sv
max_finder/max_finder_tree.sv
rtl/prio_regs_axil.sv
rtl/grant_stage.sv
rtl/prio_sched_top.sv
bench/tb_prio_sched.sv

// ==== bench/tb_prio_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_prio_sched
  import sched_pkg::*;
();

  localparam int DIRECTED_ROWS   = 9;
  localparam int ROW_COUNT       = 24;
  localparam int ROW_CYCLES      = 20;
  localparam int SETUP_CYCLES    = 400;
  localparam int WATCHDOG_CYCLES = SETUP_CYCLES + ROW_COUNT * ROW_CYCLES;

  logic                            clk;
  logic                            rst_n;
  axil_addr_t                      awaddr;
  logic                            awvalid;
  logic                            awready;
  axil_data_t                      wdata;
  logic                            wvalid;
  logic                            wready;
  axil_resp_t                      bresp;
  logic                            bvalid;
  logic                            bready;
  axil_addr_t                      araddr;
  logic                            arvalid;
  logic                            arready;
  axil_data_t                      rdata;
  axil_resp_t                      rresp;
  logic                            rvalid;
  logic                            rready;
  logic [PORT_COUNT-1:0]           req;
  logic                            grant_ready;
  logic                            grant_valid;
  port_idx_t                       grant_port;
  prio_t                           grant_prio;

  // stimulus table
  logic [PORT_COUNT-1:0]            row_mask      [ROW_COUNT];
  logic                             row_en        [ROW_COUNT];
  logic [PORT_COUNT*PRIO_WIDTH-1:0] row_prio      [ROW_COUNT];
  logic [PORT_COUNT-1:0]            row_req       [ROW_COUNT];
  logic                             row_ready     [ROW_COUNT];
  logic                             row_exp_valid [ROW_COUNT];
  port_idx_t                        row_exp_port  [ROW_COUNT];
  prio_t                            row_exp_prio  [ROW_COUNT];
  int                               row_fill = 0;

  // grant model
  int                               cnt_model [PORT_COUNT];
  port_idx_t                        last_port = '0;
  prio_t                            last_prio = '0;
  logic                             last_seen = 1'b0;
  logic [PORT_COUNT-1:0]            cfg_mask;
  logic                             cfg_en;
  logic [PORT_COUNT*PRIO_WIDTH-1:0] cfg_prio;

  int                               checks = 0;
  int                               errors = 0;

  prio_sched_top UUT (
    .clk (clk), .rst_n (rst_n),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .req (req), .grant_ready (grant_ready),
    .grant_valid (grant_valid), .grant_port (grant_port), .grant_prio (grant_prio)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // enabled requester with the highest priority and the first index on a tie
  function automatic void ref_winner(
    input logic [PORT_COUNT-1:0] mask, input logic en,
    input logic [PORT_COUNT*PRIO_WIDTH-1:0] prios, input logic [PORT_COUNT-1:0] rq,
    output logic found, output port_idx_t port, output prio_t prio);
    prio_t p;
    found = 1'b0;
    port  = '0;
    prio  = '0;
    for (int i = 0; i < PORT_COUNT; i++) begin
      p = prios[i*PRIO_WIDTH +: PRIO_WIDTH];
      if (en && mask[i] && rq[i] && (!found || p > prio)) begin
        found = 1'b1;
        port  = port_idx_t'(i);
        prio  = p;
      end
    end
  endfunction

  task automatic check_bit(input string where, input string sig, input logic got,
                           input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s %s: got %0b expected %0b", $time, where, sig, got, exp);
    end
  endtask

  task automatic check_grant(input string where, input logic exp_valid,
                             input port_idx_t exp_port, input prio_t exp_prio);
    check_bit(where, "grant_valid", grant_valid, exp_valid);
    if (exp_valid && grant_valid) begin
      checks++;
      if (grant_port !== exp_port) begin
        errors++;
        $display("[ERROR] %0t %s grant_port: got %0d expected %0d",
                 $time, where, grant_port, exp_port);
      end
      if (grant_prio !== exp_prio) begin
        errors++;
        $display("[ERROR] %0t %s grant_prio: got 0x%02h expected 0x%02h",
                 $time, where, grant_prio, exp_prio);
      end
    end
  endtask

  task automatic check_data(input string where, input axil_data_t got, input axil_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s rdata: got 0x%08h expected 0x%08h", $time, where, got, exp);
    end
  endtask

  task automatic check_resp(input string where, input string sig, input axil_resp_t got,
                            input axil_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s %s: got %0d expected %0d", $time, where, sig, got, exp);
    end
  endtask

  task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
                              input axil_resp_t exp_resp, input string where);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    next_cycle();
    while (!awready) begin
      next_cycle();
    end
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      next_cycle();
    end
    check_resp(where, "bresp", bresp, exp_resp);
  endtask

  task automatic read_expect(input axil_addr_t addr, input axil_data_t exp_data,
                             input axil_resp_t exp_resp, input string where);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    next_cycle();
    while (!arready) begin
      next_cycle();
    end
    next_cycle();
    arvalid = 1'b0;
    while (!rvalid) begin
      next_cycle();
    end
    check_data(where, rdata, exp_data);
    check_resp(where, "rresp", rresp, exp_resp);
  endtask

  task automatic add_row(input logic [PORT_COUNT-1:0] mask, input logic en,
                         input logic [PORT_COUNT*PRIO_WIDTH-1:0] prios,
                         input logic [PORT_COUNT-1:0] rq, input logic rdy,
                         input logic ev, input port_idx_t ep, input prio_t eq);
    row_mask[row_fill]      = mask;
    row_en[row_fill]        = en;
    row_prio[row_fill]      = prios;
    row_req[row_fill]       = rq;
    row_ready[row_fill]     = rdy;
    row_exp_valid[row_fill] = ev;
    row_exp_port[row_fill]  = ep;
    row_exp_prio[row_fill]  = eq;
    row_fill++;
  endtask

  task automatic build_table();
    logic [31:0]                      rng;
    logic [PORT_COUNT*PRIO_WIDTH-1:0] prios;
    logic                             f;
    port_idx_t                        p;
    prio_t                            q;
    add_row(8'hFF, 1'b1, 64'h8070_6050_4030_2010, 8'hFF, 1'b1, 1'b1, 3'd7, 8'h80);
    add_row(8'hFF, 1'b1, 64'h5555_5555_5555_5555, 8'h68, 1'b1, 1'b1, 3'd3, 8'h55);
    add_row(8'hFF, 1'b1, 64'h0, 8'h20, 1'b1, 1'b1, 3'd5, 8'h00);
    add_row(8'hFF, 1'b1, 64'hFFFF_FFFF_FF00_FFFF, 8'h04, 1'b1, 1'b1, 3'd2, 8'h00);
    add_row(8'h0F, 1'b1, 64'hF0E0_D0C0_0403_0201, 8'hFF, 1'b1, 1'b1, 3'd3, 8'h04);
    // masked requesters and global disable
    add_row(8'h0F, 1'b1, 64'hF0E0_D0C0_0403_0201, 8'hF0, 1'b1, 1'b0, 3'd0, 8'h00);
    add_row(8'hFF, 1'b0, 64'h8070_6050_4030_2010, 8'hFF, 1'b1, 1'b0, 3'd0, 8'h00);
    // back-pressure rows
    add_row(8'hFF, 1'b1, 64'h0102_0304_0506_0708, 8'h81, 1'b0, 1'b1, 3'd0, 8'h08);
    add_row(8'hFF, 1'b1, 64'h0, 8'h40, 1'b0, 1'b1, 3'd6, 8'h00);
    rng = 32'd22493;
    for (int r = DIRECTED_ROWS; r < ROW_COUNT; r++) begin
      rng = xorshift32(rng);
      prios[31:0] = xorshift32(rng);
      prios[63:32] = xorshift32(prios[31:0]);
      ref_winner(rng[7:0] | rng[15:8], rng[19:16] != 4'd0, prios, rng[31:24], f, p, q);
      add_row(rng[7:0] | rng[15:8], rng[19:16] != 4'd0, prios, rng[31:24], rng[20], f, p, q);
      rng = prios[63:32];
    end
  endtask

  task automatic record_grant(input port_idx_t p, input prio_t q);
    cnt_model[p]++;
    last_port = p;
    last_prio = q;
    last_seen = 1'b1;
  endtask

  task automatic run_row(input int r);
    string                 where;
    logic [PORT_COUNT-1:0] alt_req;
    logic                  nxt_found;
    port_idx_t             nxt_port;
    prio_t                 nxt_prio;
    where = $sformatf("row %0d", r);
    cfg_mask = row_mask[r];
    cfg_en   = row_en[r];
    cfg_prio = row_prio[r];
    write_expect(REG_MASK, axil_data_t'(cfg_mask), RESP_OKAY, where);
    write_expect(REG_CTRL, axil_data_t'(cfg_en), RESP_OKAY, where);
    write_expect(REG_PRIO_LO, cfg_prio[31:0], RESP_OKAY, where);
    write_expect(REG_PRIO_HI, cfg_prio[63:32], RESP_OKAY, where);
    req         = row_req[r];
    grant_ready = row_ready[r];
    next_cycle();
    check_grant(where, row_exp_valid[r], row_exp_port[r], row_exp_prio[r]);
    if (row_exp_valid[r] && !row_ready[r]) begin
      alt_req = ~row_req[r];
      for (int k = 0; k < 3; k++) begin
        req = (k % 2 == 0) ? alt_req : 8'hFF;
        next_cycle();
        check_grant({where, " stalled"}, 1'b1, row_exp_port[r], row_exp_prio[r]);
      end
      ref_winner(cfg_mask, cfg_en, cfg_prio, alt_req, nxt_found, nxt_port, nxt_prio);
      req         = alt_req;
      grant_ready = 1'b1;
      next_cycle();
      record_grant(row_exp_port[r], row_exp_prio[r]);
      check_grant({where, " next"}, nxt_found, nxt_port, nxt_prio);
      req = '0;
      next_cycle();
      if (nxt_found) begin
        record_grant(nxt_port, nxt_prio);
      end
    end else begin
      req = '0;
      next_cycle();
      if (row_exp_valid[r] && row_ready[r]) begin
        record_grant(row_exp_port[r], row_exp_prio[r]);
      end
    end
    check_grant({where, " drained"}, 1'b0, '0, '0);
    grant_ready = 1'b0;
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main
    axil_data_t last_exp;
    rst_n       = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    req         = '0;
    grant_ready = 1'b0;
    for (int i = 0; i < PORT_COUNT; i++) begin
      cnt_model[i] = 0;
    end
    build_table();
    repeat (8) @(posedge clk);
    #2;
    check_grant("reset", 1'b0, '0, '0);
    check_bit("reset", "awready", awready, 1'b0);
    check_bit("reset", "wready", wready, 1'b0);
    check_bit("reset", "bvalid", bvalid, 1'b0);
    check_bit("reset", "arready", arready, 1'b0);
    check_bit("reset", "rvalid", rvalid, 1'b0);
    rst_n = 1'b1;
    next_cycle();

    // reset values of the register map
    read_expect(REG_CTRL, 32'h0, RESP_OKAY, "ctrl reset");
    read_expect(REG_MASK, 32'hFF, RESP_OKAY, "mask reset");
    read_expect(REG_PRIO_LO, 32'h0, RESP_OKAY, "prio_lo reset");
    read_expect(REG_PRIO_HI, 32'h0, RESP_OKAY, "prio_hi reset");
    read_expect(REG_LAST, 32'h0, RESP_OKAY, "last reset");
    for (int i = 0; i < PORT_COUNT; i++) begin
      read_expect(REG_CNT_BASE + axil_addr_t'(4 * i), 32'h0, RESP_OKAY, "cnt reset");
    end

    write_expect(REG_PRIO_LO, 32'hA5C3_0F96, RESP_OKAY, "prio_lo write");
    read_expect(REG_PRIO_LO, 32'hA5C3_0F96, RESP_OKAY, "prio_lo readback");
    write_expect(REG_PRIO_HI, 32'h1234_5678, RESP_OKAY, "prio_hi write");
    read_expect(REG_PRIO_HI, 32'h1234_5678, RESP_OKAY, "prio_hi readback");
    write_expect(REG_MASK, 32'hFFFF_FF5A, RESP_OKAY, "mask write");
    read_expect(REG_MASK, 32'h0000_005A, RESP_OKAY, "mask readback");
    write_expect(REG_CTRL, 32'h0000_0003, RESP_OKAY, "ctrl write");
    read_expect(REG_CTRL, 32'h0000_0001, RESP_OKAY, "ctrl readback");

    for (int r = 0; r < ROW_COUNT; r++) begin
      run_row(r);
    end

    // read-only and unmapped addresses
    write_expect(REG_LAST, 32'hFFFF_FFFF, RESP_SLVERR, "last write");
    write_expect(REG_CNT_BASE, 32'h0000_1234, RESP_SLVERR, "cnt write");
    write_expect(6'h14, 32'hDEAD_BEEF, RESP_SLVERR, "unmapped write");
    read_expect(6'h14, 32'h0, RESP_SLVERR, "unmapped read");
    read_expect(6'h1C, 32'h0, RESP_SLVERR, "unmapped read");
    read_expect(REG_CTRL, axil_data_t'(cfg_en), RESP_OKAY, "ctrl kept");
    read_expect(REG_MASK, axil_data_t'(cfg_mask), RESP_OKAY, "mask kept");
    read_expect(REG_PRIO_LO, cfg_prio[31:0], RESP_OKAY, "prio_lo kept");
    read_expect(REG_PRIO_HI, cfg_prio[63:32], RESP_OKAY, "prio_hi kept");

    for (int i = 0; i < PORT_COUNT; i++) begin
      read_expect(REG_CNT_BASE + axil_addr_t'(4 * i), axil_data_t'(cnt_model[i]),
                  RESP_OKAY, $sformatf("cnt port %0d", i));
    end
    last_exp        = '0;
    last_exp[2:0]   = last_port;
    last_exp[15:8]  = last_prio;
    last_exp[31]    = last_seen;
    read_expect(REG_LAST, last_exp, RESP_OKAY, "last grant");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

  localparam int PORT_COUNT  = 8;
  localparam int PRIO_WIDTH  = 8;
  localparam int PORT_IDX_W  = $clog2(PORT_COUNT);
  localparam int CNT_WIDTH   = 16;
  localparam int AXIL_ADDR_W = 6;
  localparam int AXIL_DATA_W = 32;

  typedef logic [PRIO_WIDTH-1:0]  prio_t;
  typedef logic [PORT_IDX_W-1:0]  port_idx_t;
  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [1:0]             axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // register map, byte offsets
  localparam axil_addr_t REG_CTRL     = 6'h00;
  localparam axil_addr_t REG_MASK     = 6'h04;
  localparam axil_addr_t REG_PRIO_LO  = 6'h08;
  localparam axil_addr_t REG_PRIO_HI  = 6'h0C;
  localparam axil_addr_t REG_LAST     = 6'h10;
  localparam axil_addr_t REG_CNT_BASE = 6'h20;

  // counter window in word units
  localparam int CNT_BASE_WORD = REG_CNT_BASE / 4;

  // last-grant word layout
  localparam int LAST_PORT_LSB = 0;
  localparam int LAST_PRIO_LSB = 8;
  localparam int LAST_SEEN_BIT = 31;

  localparam logic [PORT_COUNT-1:0] MASK_RESET = '1;

endpackage

`default_nettype wire

// ==== max_finder/max_finder_pow2.sv ====
`timescale 1ns/1ps
`default_nettype none

module max_finder_pow2 #(
  parameter int PORT_COUNT = 16,
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = $clog2(PORT_COUNT)
) (
  input  wire [PORT_COUNT*DATA_WIDTH-1:0] values,

  output logic [DATA_WIDTH-1:0]           max_val,
  output logic [ADDR_WIDTH-1:0]           max_ptr
);

  // heap layout: node n has children 2n and 2n+1, root is node 1
  // leaf for port i is node PORT_COUNT+i
  logic [DATA_WIDTH-1:0] node_val [1:2*PORT_COUNT-1];
  logic [ADDR_WIDTH-1:0] node_ptr [1:2*PORT_COUNT-1];

  genvar i;
  genvar lvl;
  genvar n;

  generate
    for (i = 0; i < PORT_COUNT; i++) begin : g_leaf
      assign node_val[PORT_COUNT+i] = values[i*DATA_WIDTH +: DATA_WIDTH];
      assign node_ptr[PORT_COUNT+i] = '0;
    end

    // lvl counts the index bits resolved so far
    for (lvl = 1; lvl <= ADDR_WIDTH; lvl++) begin : g_lvl
      localparam logic [ADDR_WIDTH-1:0] LVL_BIT = ADDR_WIDTH'(1) << (lvl - 1);

      for (n = PORT_COUNT >> lvl; n < (PORT_COUNT >> (lvl - 1)); n++) begin : g_node
        logic upper_wins;

        // strict compare, so equal values keep the lower index
        assign upper_wins = node_val[2*n+1] > node_val[2*n];

        assign node_val[n] = upper_wins ? node_val[2*n+1] : node_val[2*n];
        assign node_ptr[n] = upper_wins ? (node_ptr[2*n+1] | LVL_BIT) : node_ptr[2*n];
      end
    end
  endgenerate

  assign max_val = node_val[1];
  assign max_ptr = node_ptr[1];

endmodule

`default_nettype wire

// ==== max_finder/max_finder_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module max_finder_tree #(
  parameter int PORT_COUNT = 16,
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = $clog2(PORT_COUNT)
) (
  input  wire [PORT_COUNT*DATA_WIDTH-1:0] values,
  input  wire [PORT_COUNT-1:0]            valids,

  output logic [DATA_WIDTH-1:0]           max_val,
  output logic [ADDR_WIDTH-1:0]           max_ptr,
  output logic                            max_valid
);

  localparam int CEIL_PORT_CNT = 2 ** $clog2(PORT_COUNT);
  // valid flag sits above the value
  localparam int EXT_WIDTH     = DATA_WIDTH + 1;

  logic [CEIL_PORT_CNT*EXT_WIDTH-1:0] ext_values;
  logic [EXT_WIDTH-1:0]               win_entry;

  // invalid ports and padding entries stay all zero
  always_comb begin
    ext_values = '0;
    for (int i = 0; i < PORT_COUNT; i++) begin
      if (valids[i]) begin
        ext_values[i*EXT_WIDTH +: EXT_WIDTH] = {1'b1, values[i*DATA_WIDTH +: DATA_WIDTH]};
      end
    end
  end

  max_finder_pow2 #(
    .PORT_COUNT (CEIL_PORT_CNT),
    .DATA_WIDTH (EXT_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_pow2 (
    .values  (ext_values),
    .max_val (win_entry),
    .max_ptr (max_ptr)
  );

  assign max_val   = win_entry[DATA_WIDTH-1:0];
  assign max_valid = win_entry[DATA_WIDTH];

  // a reported winner must be one of the valid inputs
  always_comb begin
    assert final (!max_valid || valids[max_ptr])
      else $error("max_finder_tree: winner %0d is not a valid port", max_ptr);
  end

endmodule

`default_nettype wire

// ==== rtl/grant_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module grant_stage
  import sched_pkg::*;
(
  input  wire                              clk,
  input  wire                              rst_n,

  input  wire [PORT_COUNT-1:0]             req,
  input  wire                              sched_enable,
  input  wire [PORT_COUNT-1:0]             port_mask,
  input  wire [PORT_COUNT*PRIO_WIDTH-1:0]  port_prio,

  input  wire                              grant_ready,
  output logic                             grant_valid,
  output port_idx_t                        grant_port,
  output prio_t                            grant_prio,
  output logic                             grant_fire
);

  logic [PORT_COUNT-1:0] cand;
  prio_t                 win_prio;
  port_idx_t             win_port;
  logic                  win_valid;
  logic                  slot_load;

  assign cand = req & port_mask & {PORT_COUNT{sched_enable}};

  max_finder_tree #(
    .PORT_COUNT (PORT_COUNT),
    .DATA_WIDTH (PRIO_WIDTH),
    .ADDR_WIDTH (PORT_IDX_W)
  ) u_tree (
    .values    (port_prio),
    .valids    (cand),
    .max_val   (win_prio),
    .max_ptr   (win_port),
    .max_valid (win_valid)
  );

  assign grant_fire = grant_valid && grant_ready;
  // slot is empty or being emptied this cycle
  assign slot_load  = !grant_valid || grant_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_valid <= 1'b0;
    end else if (slot_load) begin
      grant_valid <= win_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (slot_load && win_valid) begin
      grant_port <= win_port;
      grant_prio <= win_prio;
    end
  end

  // stalled grant keeps its payload
  a_stall_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    grant_valid && !grant_ready |=> grant_valid && $stable(grant_port) && $stable(grant_prio)
  ) else $error("grant_stage: grant changed under back-pressure");

endmodule

`default_nettype wire

// ==== rtl/prio_regs_axil.sv ====
`timescale 1ns/1ps
`default_nettype none

module prio_regs_axil
  import sched_pkg::*;
(
  input  wire                              clk,
  input  wire                              rst_n,

  // write address and data
  input  wire axil_addr_t                  awaddr,
  input  wire                              awvalid,
  output logic                             awready,
  input  wire axil_data_t                  wdata,
  input  wire                              wvalid,
  output logic                             wready,
  output axil_resp_t                       bresp,
  output logic                             bvalid,
  input  wire                              bready,

  // read address and data
  input  wire axil_addr_t                  araddr,
  input  wire                              arvalid,
  output logic                             arready,
  output axil_data_t                       rdata,
  output axil_resp_t                       rresp,
  output logic                             rvalid,
  input  wire                              rready,

  // accepted grants
  input  wire                              grant_fire,
  input  wire port_idx_t                   grant_port,
  input  wire prio_t                       grant_prio,

  output logic                             sched_enable,
  output logic [PORT_COUNT-1:0]            port_mask,
  output logic [PORT_COUNT*PRIO_WIDTH-1:0] port_prio
);

  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_ok;
  logic                   rd_ok;
  axil_data_t             rd_data;
  axil_data_t             last_word;
  logic [AXIL_ADDR_W-3:0] ar_word;
  logic                   cnt_hit;
  port_idx_t              cnt_sel;

  logic [CNT_WIDTH-1:0]   grant_cnt [PORT_COUNT];
  port_idx_t              last_port;
  prio_t                  last_prio;
  logic                   last_seen;

  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;

  // write channel, one transaction at a time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !awready && !bvalid;
      wready  <= awvalid && wvalid && !awready && !bvalid;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  assign wr_ok = (awaddr == REG_CTRL) || (awaddr == REG_MASK) ||
                 (awaddr == REG_PRIO_LO) || (awaddr == REG_PRIO_HI);

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sched_enable <= 1'b0;
      port_mask    <= MASK_RESET;
      port_prio    <= '0;
    end else if (wr_fire) begin
      case (awaddr)
        REG_CTRL:    sched_enable <= wdata[0];
        REG_MASK:    port_mask <= wdata[PORT_COUNT-1:0];
        REG_PRIO_LO: port_prio[AXIL_DATA_W-1:0] <= wdata;
        REG_PRIO_HI: port_prio[2*AXIL_DATA_W-1:AXIL_DATA_W] <= wdata;
        default:     ;
      endcase
    end
  end

  // grant statistics
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PORT_COUNT; i++) begin
        grant_cnt[i] <= '0;
      end
      last_port <= '0;
      last_prio <= '0;
      last_seen <= 1'b0;
    end else if (grant_fire) begin
      if (grant_cnt[grant_port] != {CNT_WIDTH{1'b1}}) begin
        grant_cnt[grant_port] <= grant_cnt[grant_port] + 1'b1;
      end
      last_port <= grant_port;
      last_prio <= grant_prio;
      last_seen <= 1'b1;
    end
  end

  always_comb begin
    last_word = '0;
    last_word[LAST_PORT_LSB +: PORT_IDX_W] = last_port;
    last_word[LAST_PRIO_LSB +: PRIO_WIDTH] = last_prio;
    last_word[LAST_SEEN_BIT]               = last_seen;
  end

  // counter window decode
  assign ar_word = araddr[AXIL_ADDR_W-1:2];
  assign cnt_hit = (araddr[1:0] == 2'b00) && (int'(ar_word) >= CNT_BASE_WORD) &&
                   (int'(ar_word) < CNT_BASE_WORD + PORT_COUNT);
  assign cnt_sel = port_idx_t'(int'(ar_word) - CNT_BASE_WORD);

  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b1;
    case (araddr)
      REG_CTRL:    rd_data = AXIL_DATA_W'(sched_enable);
      REG_MASK:    rd_data = AXIL_DATA_W'(port_mask);
      REG_PRIO_LO: rd_data = port_prio[AXIL_DATA_W-1:0];
      REG_PRIO_HI: rd_data = port_prio[2*AXIL_DATA_W-1:AXIL_DATA_W];
      REG_LAST:    rd_data = last_word;
      default: begin
        if (cnt_hit) begin
          rd_data = AXIL_DATA_W'(grant_cnt[cnt_sel]);
        end else begin
          rd_ok = 1'b0;
        end
      end
    endcase
  end

  // read channel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_data;
      rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // no write response without a handshake on the edge before
  a_bvalid_after_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready)
  ) else $error("prio_regs_axil: bvalid rose without a write handshake");

endmodule

`default_nettype wire

// ==== rtl/prio_sched_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module prio_sched_top
  import sched_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst_n,

  input  wire axil_addr_t       awaddr,
  input  wire                   awvalid,
  output logic                  awready,
  input  wire axil_data_t       wdata,
  input  wire                   wvalid,
  output logic                  wready,
  output axil_resp_t            bresp,
  output logic                  bvalid,
  input  wire                   bready,
  input  wire axil_addr_t       araddr,
  input  wire                   arvalid,
  output logic                  arready,
  output axil_data_t            rdata,
  output axil_resp_t            rresp,
  output logic                  rvalid,
  input  wire                   rready,

  input  wire [PORT_COUNT-1:0]  req,
  input  wire                   grant_ready,
  output logic                  grant_valid,
  output port_idx_t             grant_port,
  output prio_t                 grant_prio
);

  logic                              sched_enable;
  logic [PORT_COUNT-1:0]             port_mask;
  logic [PORT_COUNT*PRIO_WIDTH-1:0]  port_prio;
  logic                              grant_fire;

  prio_regs_axil u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .grant_fire   (grant_fire),
    .grant_port   (grant_port),
    .grant_prio   (grant_prio),
    .sched_enable (sched_enable),
    .port_mask    (port_mask),
    .port_prio    (port_prio)
  );

  grant_stage u_grant (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .sched_enable (sched_enable),
    .port_mask    (port_mask),
    .port_prio    (port_prio),
    .grant_ready  (grant_ready),
    .grant_valid  (grant_valid),
    .grant_port   (grant_port),
    .grant_prio   (grant_prio),
    .grant_fire   (grant_fire)
  );

endmodule

`default_nettype wire
